//--- design/panel_pkg.sv
// LED panel shared definitions.
// Panel geometry, brightness timing, APB address map and common vector types.
`default_nettype none

package panel_pkg;

    // Panel geometry.
    localparam int PANEL_COLS = 8;
    localparam int PANEL_ROWS = 4;
    localparam int PIXEL_COUNT = PANEL_COLS * PANEL_ROWS;

    // Bits per pixel, one bit plane per bit.
    localparam int BRIGHTNESS_LEVELS = 4;
    // Output-enable cycles of plane 0, doubled for each higher plane.
    localparam int BRIGHTNESS_BASE_TIMEOUT = 4;
    // Remaining cycles at or below which the next plane may be shifted.
    localparam int BRIGHTNESS_STATE_TIMEOUT_OVERLAP = 10;
    // Wide enough for the base timeout shifted by the top plane index.
    localparam int TIMEOUT_WIDTH_BITS = $clog2(BRIGHTNESS_BASE_TIMEOUT) + BRIGHTNESS_LEVELS;

    // APB word address of the control register.
    localparam int CTRL_ADDR = 32;

    typedef logic [BRIGHTNESS_LEVELS-1:0]          pixel_t;
    typedef logic [BRIGHTNESS_LEVELS-1:0]          plane_mask_t;
    typedef logic [$clog2(BRIGHTNESS_LEVELS)-1:0]  plane_index_t;
    typedef logic [$clog2(PANEL_ROWS)-1:0]         row_addr_t;
    typedef logic [$clog2(PANEL_COLS)-1:0]         col_addr_t;
    typedef logic [$clog2(PIXEL_COUNT)-1:0]        pix_addr_t;
    typedef logic [5:0]                            apb_addr_t;
    typedef logic [TIMEOUT_WIDTH_BITS-1:0]         timeout_t;

    // Row scanner states.
    typedef enum logic [2:0] {
        scan_idle,
        scan_wait_overlap,
        scan_shift_low,
        scan_shift_high,
        scan_wait_oe,
        scan_latch
    } scan_state_t;

endpackage

`default_nettype wire

//--- design/plane_if.sv
// Scanner to brightness timer link.
// Carries the displayed plane, the latch pulse and the output-enable status.
`timescale 1ns/1ps
`default_nettype none

interface plane_if (
    input logic clk_in,
    input logic rst_n
);
    import panel_pkg::*;

    // One-hot mask of the plane just latched.
    plane_mask_t plane_mask;
    // High for the single latch cycle.
    logic        row_latch;
    // High while the LEDs of the latched plane are lit.
    logic        output_enable;
    // High while too much of the window is left to start shifting.
    logic        exceeded_overlap_time;

    modport scanner (
        input  clk_in, rst_n,
        output plane_mask, row_latch,
        input  output_enable, exceeded_overlap_time
    );

    modport timer (
        input  clk_in, rst_n,
        input  plane_mask, row_latch,
        output output_enable, exceeded_overlap_time
    );

endinterface

`default_nettype wire

//--- design/timeout.sv
// Retriggerable down-counter.
// Loads a value on a rising start edge and counts down to zero.
`timescale 1ns/1ps
`default_nettype none

module timeout (
    input  logic                clk_in,
    input  logic                rst_n,
    input  logic                start,
    input  panel_pkg::timeout_t value,
    output panel_pkg::timeout_t counter,
    output logic                running
);
    import panel_pkg::*;

    logic start_q;
    logic start_edge;

    // Rising edge of start, one cycle wide.
    assign start_edge = start & ~start_q;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            // Start held high through reset must not fire a load.
            start_q <= 1'b1;
            counter <= '0;
        end else begin
            start_q <= start;
            if (start_edge) begin
                // A new edge reloads even while still counting.
                counter <= value;
            end else if (counter != '0) begin
                counter <= counter - timeout_t'(1);
            end
        end
    end

    // Running for exactly value cycles after the load.
    assign running = (counter != '0);

endmodule

`default_nettype wire

//--- design/brightness_timeout.sv
// Brightness timer for binary-coded modulation.
// Turns the one-hot plane mask into a weighted output-enable window
// and flags when the window is close enough to its end for overlap.
`timescale 1ns/1ps
`default_nettype none

module brightness_timeout (
    input logic    clk_in,
    input logic    rst_n,
    plane_if.timer plane
);
    import panel_pkg::*;

    plane_index_t plane_index;
    logic         one_hot;
    logic         latch_released;
    timeout_t     plane_timeout;
    timeout_t     remaining;

    // Priority encoder, lowest set bit wins.
    always_comb begin
        plane_index = '0;
        for (int i = BRIGHTNESS_LEVELS - 1; i >= 0; i--) begin
            if (plane.plane_mask[i]) begin
                plane_index = plane_index_t'(i);
            end
        end
    end

    // Only a clean one-hot mask selects a weighted window.
    assign one_hot = ($countones(plane.plane_mask) == 1);

    // Plane k is lit for base << k cycles.
    // A corrupt mask falls back to the shortest possible window.
    assign plane_timeout = one_hot ?
                           (timeout_t'(BRIGHTNESS_BASE_TIMEOUT) << plane_index) :
                           timeout_t'(1);

    // Window starts when the latch pulse ends.
    assign latch_released = ~plane.row_latch;

    timeout i_oe_timer (
        .clk_in  (clk_in),
        .rst_n   (rst_n),
        .start   (latch_released),
        .value   (plane_timeout),
        .counter (remaining),
        .running (plane.output_enable)
    );

    // Shifting of the next plane waits until the remaining count drops
    // to the overlap threshold.
    assign plane.exceeded_overlap_time =
        (remaining > timeout_t'(BRIGHTNESS_STATE_TIMEOUT_OVERLAP));

endmodule

`default_nettype wire

//--- design/pixel_store.sv
// APB frame store.
// Holds one intensity per pixel and the scan-enable control bit,
// with an asynchronous read port for the row scanner.
`timescale 1ns/1ps
`default_nettype none

module pixel_store (
    input  logic                 clk_in,
    input  logic                 rst_n,
    input  panel_pkg::apb_addr_t paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,
    input  panel_pkg::pix_addr_t pix_addr,
    output panel_pkg::pixel_t    pixel,
    output logic                 scan_enable
);
    import panel_pkg::*;

    pixel_t frame [PIXEL_COUNT];

    logic access;
    logic write_en;
    logic read_en;
    logic pix_hit;
    logic ctrl_hit;

    // Transfers complete in the access phase only.
    assign access   = psel & penable;
    assign write_en = access & pwrite;
    assign read_en  = access & ~pwrite;

    // Address decode.
    assign pix_hit  = (paddr < apb_addr_t'(PIXEL_COUNT));
    assign ctrl_hit = (paddr == apb_addr_t'(CTRL_ADDR));

    // No wait states.
    assign pready = 1'b1;

    // Anything outside the pixel range and the control word is an error.
    assign pslverr = access & ~(pix_hit | ctrl_hit);

    // Frame and control writes.
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            scan_enable <= 1'b0;
            for (int i = 0; i < PIXEL_COUNT; i++) begin
                frame[i] <= '0;
            end
        end else if (write_en) begin
            if (pix_hit) begin
                frame[pix_addr_t'(paddr)] <= pwdata[BRIGHTNESS_LEVELS-1:0];
            end
            if (ctrl_hit) begin
                scan_enable <= pwdata[0];
            end
        end
    end

    // Read data, valid in the access cycle.
    // Error reads and idle cycles return zero.
    always_comb begin
        prdata = '0;
        if (read_en) begin
            if (pix_hit) begin
                prdata[BRIGHTNESS_LEVELS-1:0] = frame[pix_addr_t'(paddr)];
            end else if (ctrl_hit) begin
                prdata[0] = scan_enable;
            end
        end
    end

    // Scanner read port.
    assign pixel = frame[pix_addr];

endmodule

`default_nettype wire

//--- design/row_scanner.sv
// Row scanner for the LED panel.
// Shifts each bit plane of each row out column by column, latches it
// and paces itself on the brightness timer so shifting overlaps the window.
`timescale 1ns/1ps
`default_nettype none

module row_scanner (
    input  logic                 clk_in,
    input  logic                 rst_n,
    input  logic                 scan_enable,
    output panel_pkg::pix_addr_t pix_addr,
    input  panel_pkg::pixel_t    pixel,
    output panel_pkg::row_addr_t row_addr,
    output logic                 data,
    output logic                 shift_clk,
    output logic                 latch,
    plane_if.scanner             plane
);
    import panel_pkg::*;

    scan_state_t state;
    scan_state_t state_next;

    // Column, plane and row of the data being shifted in.
    col_addr_t   col;
    plane_mask_t shift_mask;
    row_addr_t   shift_row;

    // Set by a latch until its window has been seen to start.
    logic        oe_pending;
    logic        window_started;
    logic        shifting;

    // The timer loads one cycle after the latch ends, so its flags
    // are stale until output enable has been seen.
    assign window_started = ~oe_pending | plane.output_enable;

    always_comb begin
        state_next = state;
        case (state)
            scan_idle: begin
                if (scan_enable) begin
                    state_next = scan_wait_overlap;
                end
            end
            scan_wait_overlap: begin
                if (!scan_enable) begin
                    state_next = scan_idle;
                end else if (window_started && !plane.exceeded_overlap_time) begin
                    state_next = scan_shift_low;
                end
            end
            scan_shift_low: begin
                state_next = scan_shift_high;
            end
            scan_shift_high: begin
                state_next = (col == '0) ? scan_wait_oe : scan_shift_low;
            end
            scan_wait_oe: begin
                // Never latch over lit LEDs.
                // A disable drops the shifted plane.
                if (!plane.output_enable) begin
                    state_next = scan_enable ? scan_latch : scan_idle;
                end
            end
            scan_latch: begin
                state_next = scan_wait_overlap;
            end
            default: begin
                state_next = scan_idle;
            end
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state            <= scan_idle;
            col              <= col_addr_t'(PANEL_COLS - 1);
            shift_mask       <= plane_mask_t'(1);
            shift_row        <= '0;
            row_addr         <= '0;
            plane.plane_mask <= plane_mask_t'(1);
            oe_pending       <= 1'b0;
        end else begin
            state <= state_next;
            if (plane.output_enable) begin
                oe_pending <= 1'b0;
            end
            case (state)
                scan_shift_high: begin
                    // Column 7 goes out first.
                    if (col == '0) begin
                        col <= col_addr_t'(PANEL_COLS - 1);
                    end else begin
                        col <= col - col_addr_t'(1);
                    end
                end
                scan_wait_oe: begin
                    // Displayed row and plane change only at the latch.
                    if (state_next == scan_latch) begin
                        row_addr         <= shift_row;
                        plane.plane_mask <= shift_mask;
                    end
                end
                scan_latch: begin
                    oe_pending <= 1'b1;
                    // Next plane; after the top plane move on to the next row.
                    shift_mask <= {shift_mask[BRIGHTNESS_LEVELS-2:0],
                                   shift_mask[BRIGHTNESS_LEVELS-1]};
                    if (shift_mask[BRIGHTNESS_LEVELS-1]) begin
                        if (shift_row == row_addr_t'(PANEL_ROWS - 1)) begin
                            shift_row <= '0;
                        end else begin
                            shift_row <= shift_row + row_addr_t'(1);
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Frame store index of the column being shifted.
    assign pix_addr = pix_addr_t'(shift_row * PANEL_COLS + col);

    // Two cycles per bit, data stable across the rising shift clock.
    assign shifting  = (state == scan_shift_low) || (state == scan_shift_high);
    assign data      = shifting & |(pixel & shift_mask);
    assign shift_clk = (state == scan_shift_high);

    // Single-cycle latch, also the timer start.
    assign latch           = (state == scan_latch);
    assign plane.row_latch = latch;

endmodule

`default_nettype wire

//--- design/led_panel_driver.sv
// HUB75-style LED panel driver top level.
// APB frame store, row scanner and brightness timer wired to the panel pins.
`timescale 1ns/1ps
`default_nettype none

module led_panel_driver (
    input  logic                 clk_in,
    input  logic                 rst_n,
    // APB slave port.
    input  panel_pkg::apb_addr_t paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,
    // Panel pins.
    output panel_pkg::row_addr_t row_addr,
    output logic                 data,
    output logic                 shift_clk,
    output logic                 latch,
    output logic                 output_enable
);
    import panel_pkg::*;

    pix_addr_t pix_addr;
    pixel_t    pixel;
    logic      scan_enable;

    // Scanner to timer link.
    plane_if plane_bus (
        .clk_in (clk_in),
        .rst_n  (rst_n)
    );

    pixel_store i_store (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .pix_addr    (pix_addr),
        .pixel       (pixel),
        .scan_enable (scan_enable)
    );

    row_scanner i_scanner (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .scan_enable (scan_enable),
        .pix_addr    (pix_addr),
        .pixel       (pixel),
        .row_addr    (row_addr),
        .data        (data),
        .shift_clk   (shift_clk),
        .latch       (latch),
        .plane       (plane_bus.scanner)
    );

    brightness_timeout i_timer (
        .clk_in (clk_in),
        .rst_n  (rst_n),
        .plane  (plane_bus.timer)
    );

    // Window from the timer drives the panel enable pin.
    assign output_enable = plane_bus.output_enable;

endmodule

`default_nettype wire

//--- verif/led_panel_driver_sva.sv
// Panel timing assertions for the row scanner.
// Latch against output enable, latch width, shift clock and plane mask.
`timescale 1ns/1ps
`default_nettype none

module led_panel_driver_sva (
    input logic                   clk_in,
    input logic                   rst_n,
    input logic                   latch,
    input logic                   shift_clk,
    input logic                   output_enable,
    input panel_pkg::plane_mask_t plane_mask
);

    // Failed assertion count.
    int failures = 0;

    // No latch over lit LEDs.
    latch_outside_window: assert property (
        @(posedge clk_in) disable iff (!rst_n)
        $rose(latch) |-> !output_enable
    ) else begin
        failures++;
        $error("latch rose while output enable was high");
    end

    // Latch lasts one cycle.
    latch_single_cycle: assert property (
        @(posedge clk_in) disable iff (!rst_n)
        latch |=> !latch
    ) else begin
        failures++;
        $error("latch held for more than one cycle");
    end

    // Shift clock quiet around the latch.
    no_shift_in_latch: assert property (
        @(posedge clk_in) disable iff (!rst_n)
        latch |-> (!shift_clk && $stable(shift_clk))
    ) else begin
        failures++;
        $error("shift clock moved during the latch");
    end

    // Exactly one plane selected.
    plane_mask_one_hot: assert property (
        @(posedge clk_in) disable iff (!rst_n)
        $onehot(plane_mask)
    ) else begin
        failures++;
        $error("plane mask is not one-hot");
    end

endmodule

bind row_scanner led_panel_driver_sva i_sva (
    .clk_in        (clk_in),
    .rst_n         (rst_n),
    .latch         (latch),
    .shift_clk     (shift_clk),
    .output_enable (plane.output_enable),
    .plane_mask    (plane.plane_mask)
);

`default_nettype wire

//--- verif/led_panel_driver_tb.sv
// Testbench for the LED panel driver.
// Loads a random frame over APB and checks the scanned panel output against a model.
`timescale 1ns/1ps
`default_nettype none

module led_panel_driver_tb;
    import panel_pkg::*;

    localparam int          TIMEOUT_CYCLES = 40000;
    localparam int          QUIET_CYCLES   = 100;
    localparam int          FRAME_LATCHES  = PANEL_ROWS * BRIGHTNESS_LEVELS;
    localparam logic [31:0] LCG_SEED       = 32'ha262;

    logic        clk_in = 1'b0;
    logic        rst_n;
    apb_addr_t   paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    row_addr_t   row_addr;
    logic        data;
    logic        shift_clk;
    logic        latch;
    logic        output_enable;

    // Reference model of the frame store.
    pixel_t      model [PIXEL_COUNT];
    logic [31:0] lcg_state;
    logic        scan_on;
    int          host_errors = 0;
    int          scan_errors = 0;
    int          latch_count = 0;
    int          cycle_count = 0;

    // Panel monitor state.
    logic [PANEL_COLS-1:0] shift_bits = '0;
    int                    bit_count = 0;
    int                    oe_len = 0;
    int                    oe_plane = 0;
    logic                  overlap_seen = 1'b0;
    int                    exp_row = 0;
    int                    exp_plane = 0;

    led_panel_driver i_dut (
        .clk_in        (clk_in),
        .rst_n         (rst_n),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .row_addr      (row_addr),
        .data          (data),
        .shift_clk     (shift_clk),
        .latch         (latch),
        .output_enable (output_enable)
    );

    // 100 ns clock.
    always #50 clk_in = ~clk_in;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic bit value_ok(input string test, input int expected, input int actual);
        if (expected != actual) begin
            $display("error %s: expected %0d, actual %0d", test, expected, actual);
        end
        return expected == actual;
    endfunction

    // Bit of each pixel in one row for one plane, column 7 in the top bit.
    function automatic logic [PANEL_COLS-1:0] plane_bits(input int row, input int plane);
        logic [PANEL_COLS-1:0] bits;
        bits = '0;
        for (int c = PANEL_COLS - 1; c >= 0; c--) begin
            bits = {bits[PANEL_COLS-2:0],
                    model[pix_addr_t'(row * PANEL_COLS + c)][plane_index_t'(plane)]};
        end
        return bits;
    endfunction

    task automatic finish_run(input bit timed_out);
        int sva_errors;
        sva_errors = i_dut.i_scanner.i_sva.failures;
        $display("errors: %0d host, %0d scan, %0d assertion, %0d timeout",
                 host_errors, scan_errors, sva_errors, int'(timed_out));
        if (host_errors + scan_errors + sva_errors + int'(timed_out) == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic apb_access(input logic write, input apb_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        // Setup phase.
        @(posedge clk_in);
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk_in);
        penable <= 1'b1;
        // Access phase ends on the first edge with pready high.
        do begin
            @(posedge clk_in);
        end while (!pready);
        rdata = prdata;
        err   = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input logic [31:0] wdata, output logic err);
        logic [31:0] unused_rdata;
        apb_access(1'b1, addr, wdata, unused_rdata, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output logic [31:0] rdata, output logic err);
        apb_access(1'b0, addr, 32'h0, rdata, err);
    endtask

    // Panel monitor, sampling the values of the cycle before each edge.
    always @(posedge clk_in) begin
        if (rst_n) begin
            if (shift_clk) begin
                shift_bits = {shift_bits[PANEL_COLS-2:0], data};
                bit_count++;
            end
            if (output_enable) begin
                oe_len++;
                // Next plane shifting while LEDs are still lit.
                if (shift_clk) begin
                    overlap_seen = 1'b1;
                end
            end else if (oe_len != 0) begin
                assert (value_ok("oe_width", BRIGHTNESS_BASE_TIMEOUT << oe_plane, oe_len))
                else scan_errors++;
                assert (overlap_seen || !scan_on) else begin
                    $display("overlap: no shift clock during the window of plane %0d", oe_plane);
                    scan_errors++;
                end
                oe_len = 0;
                overlap_seen = 1'b0;
            end
            if (latch) begin
                assert (!output_enable) else begin
                    $display("latch: latch pulse while output enable is high");
                    scan_errors++;
                end
                assert (value_ok("plane_bits", int'(plane_bits(exp_row, exp_plane)),
                                 int'(shift_bits)))
                else scan_errors++;
                // A plane dropped by a disable is shifted again in full.
                assert (bit_count != 0 && bit_count % PANEL_COLS == 0) else begin
                    $display("plane_bits: %0d bits shifted before the latch", bit_count);
                    scan_errors++;
                end
                assert (value_ok("row_addr", exp_row, int'(row_addr))) else scan_errors++;
                oe_plane = exp_plane;
                if (exp_plane == BRIGHTNESS_LEVELS - 1) begin
                    exp_plane = 0;
                    exp_row = (exp_row + 1) % PANEL_ROWS;
                end else begin
                    exp_plane++;
                end
                bit_count = 0;
                latch_count <= latch_count + 1;
            end
        end
    end

    // Run limit, far above the few thousand cycles of the test.
    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            finish_run(1'b1);
        end
    end

    initial begin
        logic        err;
        logic [31:0] rdata;
        int          target;
        int          latches_before;
        rst_n     = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        scan_on   = 1'b0;
        lcg_state = LCG_SEED;
        repeat (16) @(posedge clk_in);
        rst_n <= 1'b1;
        @(posedge clk_in);
        assert (!latch && !shift_clk && !output_enable && !pslverr && !data && row_addr == '0)
        else begin
            $display("reset: panel or APB outputs not idle after reset");
            host_errors++;
        end

        // Random frame, upper data bits are don't care.
        for (int i = 0; i < PIXEL_COUNT; i++) begin
            lcg_state = lcg_next(lcg_state);
            apb_write(apb_addr_t'(i), {lcg_state[15:0], lcg_state[31:16]}, err);
            model[pix_addr_t'(i)] = lcg_state[19:16];
            assert (value_ok("apb_status", 0, int'(err))) else host_errors++;
        end
        for (int i = 0; i < PIXEL_COUNT; i++) begin
            apb_read(apb_addr_t'(i), rdata, err);
            assert (value_ok("apb_readback", int'(model[pix_addr_t'(i)]), int'(rdata)))
            else host_errors++;
        end

        // Out-of-range accesses, then the aliased pixels must be unchanged.
        apb_write(apb_addr_t'(40), 32'hffff_ffff, err);
        assert (value_ok("apb_error", 1, int'(err))) else host_errors++;
        apb_write(apb_addr_t'(33), 32'hffff_ffff, err);
        assert (value_ok("apb_error", 1, int'(err))) else host_errors++;
        apb_read(apb_addr_t'(40), rdata, err);
        assert (value_ok("apb_error", 1, int'(err))) else host_errors++;
        assert (value_ok("apb_error_rdata", 0, int'(rdata))) else host_errors++;
        apb_read(apb_addr_t'(63), rdata, err);
        assert (value_ok("apb_error", 1, int'(err))) else host_errors++;
        assert (value_ok("apb_error_rdata", 0, int'(rdata))) else host_errors++;
        apb_read(apb_addr_t'(8), rdata, err);
        assert (value_ok("apb_after_error", int'(model[8]), int'(rdata))) else host_errors++;
        apb_read(apb_addr_t'(1), rdata, err);
        assert (value_ok("apb_after_error", int'(model[1]), int'(rdata))) else host_errors++;

        // Control register, scanning starts with the write.
        apb_read(apb_addr_t'(CTRL_ADDR), rdata, err);
        assert (value_ok("ctrl_readback", 0, int'(rdata))) else host_errors++;
        apb_write(apb_addr_t'(CTRL_ADDR), 32'h1, err);
        scan_on <= 1'b1;
        apb_read(apb_addr_t'(CTRL_ADDR), rdata, err);
        assert (value_ok("ctrl_readback", 1, int'(rdata))) else host_errors++;
        while (latch_count < 2 * FRAME_LATCHES) @(posedge clk_in);

        // Disable, let a running shift and window drain, then expect silence.
        scan_on <= 1'b0;
        apb_write(apb_addr_t'(CTRL_ADDR), 32'h0, err);
        repeat (2 * PANEL_COLS + 2) @(posedge clk_in);
        while (output_enable) @(posedge clk_in);
        latches_before = latch_count;
        repeat (QUIET_CYCLES) begin
            @(posedge clk_in);
            assert (!shift_clk && !latch && !output_enable && !data) else begin
                $display("idle: panel output active while scanning is disabled");
                host_errors++;
            end
        end
        assert (value_ok("idle_latches", latches_before, latch_count)) else host_errors++;

        // Resume and check two more frames.
        apb_write(apb_addr_t'(CTRL_ADDR), 32'h1, err);
        scan_on <= 1'b1;
        target = latch_count + 2 * FRAME_LATCHES;
        while (latch_count < target) @(posedge clk_in);
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

//--- led_panel_driver.f
design/panel_pkg.sv
design/plane_if.sv
design/timeout.sv
design/brightness_timeout.sv
design/pixel_store.sv
design/row_scanner.sv
design/led_panel_driver.sv
verif/led_panel_driver_sva.sv
verif/led_panel_driver_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := led_panel_driver_tb
FILELIST  := led_panel_driver.f
BUILD_DIR := obj_dir
RUN_FLAGS := +verilator+error+limit+1000
PASS_MSG  := >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
